// ==== verification/byteCpu_testdata.txt ====
// Per test: ack mode (0 prompt, 1 random delay), program length, program bytes,
// record count, then records as opcode, value, flags (sign carry zero parity overflow)
03
// Unary and binary ops
00 28
01 FF 02 80 03 5A
10 7F 01 20 05 07 30 10 20
60 F0 3C 70 F0 0C 80 FF 0F
90 F0 F0 A0 00 00 B0 0F 0E
C0 42 42 C0 10 20 00
0E
01 00 0C
02 7F 03
03 A5 10
10 80 13
20 FE 1A
30 00 05
60 30 00
70 FC 10
80 F0 10
90 0F 00
A0 FF 10
B0 FE 12
C0 00 04
C0 00 08
// Forward jumps over dead bytes
00 10
01 05 04 03 01 10 00 02 01 04 02 03 00 03 0F 00
05
01 06 00
04 03 00
02 00 04
04 02 00
03 F0 10
// Random ack delays
01 0B
10 FF 01 01 7F 04 00 30 0F 11 00
04
10 00 0C
01 80 13
04 00 00
30 FF 00

// ==== byteCpu.f ====
+incdir+logic
logic/cpuPkg.sv
logic/ctrlIf.sv
logic/programMemory.sv
logic/alu.sv
logic/dataPath.sv
logic/controlUnit.sv
logic/byteCpu.sv
verification/byteCpu_assert.sv
verification/byteCpuTb.sv

// ==== Bender.yml ====
package:
  name: byteCpu

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpuPkg.sv
      - logic/ctrlIf.sv
      - logic/programMemory.sv
      - logic/alu.sv
      - logic/dataPath.sv
      - logic/controlUnit.sv
      - logic/byteCpu.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verification/byteCpu_assert.sv
      - verification/byteCpuTb.sv

// ==== verification/byteCpuTb.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module byteCpuTb;

    logic               clock;
    logic               reset;
    logic               loadReq;
    logic [`ADDR_W-1:0] loadAddr;
    logic [`DATA_W-1:0] loadData;
    logic               loadAck;
    logic               run;
    logic               resultReq;
    logic [`DATA_W-1:0] resultOpcode;
    logic [`DATA_W-1:0] resultValue;
    logic [`FLAG_W-1:0] resultFlags;
    logic               resultAck;
    logic               done;

    logic [`DATA_W-1:0] testData [256];     // Raw words from the data file
    int                 readPtr;            // Next unread word
    int                 watchdogCycles;     // Zero until the file is parsed

    byteCpu dut_i (
        .clock(clock), .reset(reset),
        .loadReq(loadReq), .loadAddr(loadAddr), .loadData(loadData), .loadAck(loadAck),
        .run(run),
        .resultReq(resultReq), .resultOpcode(resultOpcode), .resultValue(resultValue),
        .resultFlags(resultFlags), .resultAck(resultAck),
        .done(done)
    );

    always #2 clock = ~clock;               // 4 ns period

    task automatic checkValue(input logic [15:0] actual, input logic [15:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERR %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic applyReset();
        @(posedge clock);
        reset <= 1'b0;
        repeat (16) @(posedge clock);
        reset <= 1'b1;
    endtask

    // One full four-phase write of a program byte
    task automatic loadByte(input logic [`ADDR_W-1:0] addr, input logic [`DATA_W-1:0] data);
        @(posedge clock);
        loadAddr <= addr;
        loadData <= data;
        loadReq  <= 1'b1;
        do @(negedge clock); while (!loadAck);
        @(posedge clock);
        loadReq <= 1'b0;
        repeat (2) @(negedge clock);        // Ack falls one cycle after the drop
        checkValue(loadAck, 1'b0, $sformatf("loadAck still high at address %0d", addr));
    endtask

    task automatic checkRecord(input logic [`DATA_W-1:0] expOp, input logic [`DATA_W-1:0] expVal,
                               input logic [`DATA_W-1:0] expFlags, input int index);
        checkValue(resultOpcode, expOp, $sformatf("record %0d opcode", index));
        checkValue(resultValue, expVal, $sformatf("record %0d value", index));
        checkValue(resultFlags, expFlags, $sformatf("record %0d flags", index));
    endtask

    task automatic takeRecord(input bit randomAck, input int index);
        int unsigned holdCycles;
        do @(negedge clock); while (!resultReq && !done);
        checkValue(done, 1'b0, $sformatf("done raised before record %0d", index));
        checkRecord(testData[readPtr], testData[readPtr + 1], testData[readPtr + 2], index);
        holdCycles = randomAck ? $urandom % 8 : 0;
        if (holdCycles > 0) begin
            repeat (holdCycles) @(negedge clock);
            checkRecord(testData[readPtr], testData[readPtr + 1], testData[readPtr + 2], index);
        end
        @(posedge clock);
        resultAck <= 1'b1;
        do @(negedge clock); while (resultReq);
        @(posedge clock);
        resultAck <= 1'b0;
        readPtr += 3;
    endtask

    task automatic runTest(input int testIndex);
        bit randomAck;
        int progLen;
        int recCount;
        int i;
        randomAck = testData[readPtr][0];
        progLen   = testData[readPtr + 1];
        recCount  = testData[readPtr + 2 + progLen];
        $display("Test %0d: %0d bytes, %0d records", testIndex, progLen, recCount);
        applyReset();
        for (i = 0; i < progLen; i++) begin
            loadByte(`ADDR_W'(i), testData[readPtr + 2 + i]);
        end
        readPtr += 3 + progLen;
        @(posedge clock);
        run <= 1'b1;
        for (i = 0; i < recCount; i++) begin
            takeRecord(randomAck, i);
        end
        do @(negedge clock); while (!done && !resultReq);
        checkValue(resultReq, 1'b0, "resultReq after the last record");
        repeat (10) begin                   // Halted CPU stays quiet
            @(negedge clock);
            checkValue(resultReq, 1'b0, "resultReq after done");
            checkValue(done, 1'b1, "done dropped");
        end
        @(posedge clock);
        run <= 1'b0;
    endtask

    // Budget of 200 cycles per record and 40 per program byte plus reset
    function automatic int cyclesBudget();
        int ptr;
        int budget;
        int progLen;
        int recCount;
        int t;
        ptr    = 1;
        budget = 0;
        for (t = 0; t < testData[0]; t++) begin
            progLen  = testData[ptr + 1];
            recCount = testData[ptr + 2 + progLen];
            budget   = budget + 200 * recCount + 40 * progLen + 40;
            ptr      = ptr + 3 + progLen + 3 * recCount;
        end
        return budget;
    endfunction

    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding", watchdogCycles);
        $display("TEST FAILED");
        $fatal(1, "Simulation hung");
    end

    initial begin
        int testCount;
        int t;
        clock          = 1'b0;
        reset          = 1'b1;
        loadReq        = 1'b0;
        loadAddr       = '0;
        loadData       = '0;
        run            = 1'b0;
        resultAck      = 1'b0;
        watchdogCycles = 0;
        void'($urandom(60));
        $readmemh("verification/byteCpu_testdata.txt", testData);
        testCount = testData[0];
        if (testCount == 0) begin
            $display("The data file holds no tests or could not be read");
            $display("TEST FAILED");
            $fatal(1, "No stimulus");
        end else begin
            watchdogCycles = cyclesBudget();
            readPtr        = 1;
            for (t = 0; t < testCount; t++) begin
                runTest(t);
            end
            $display("TEST PASSED");
            $finish;
        end
    end

endmodule

// ==== verification/byteCpu_assert.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module byteCpuAssert (
    input logic               clock,
    input logic               reset,
    input logic               loadReq,
    input logic               loadAck,
    input logic               resultReq,
    input logic [`DATA_W-1:0] resultOpcode,
    input logic [`DATA_W-1:0] resultValue,
    input logic [`FLAG_W-1:0] resultFlags,
    input logic               resultAck,
    input logic               done
);

    // Record frozen while the host has not answered
    property recordHeld;
        @(posedge clock) disable iff (!reset)
            resultReq && !resultAck |=> resultReq && $stable(resultOpcode) &&
                                        $stable(resultValue) && $stable(resultFlags);
    endproperty

    assert property (recordHeld)
        else $error("Result record dropped or changed before resultAck");

    assert property (@(posedge clock) disable iff (!reset) $rose(loadAck) |-> loadReq)
        else $error("loadAck rose without loadReq");

    assert property (@(posedge clock) disable iff (!reset) done |=> done)
        else $error("done fell while out of reset");

    assert property (@(posedge clock) !reset |-> !resultReq && !done)  // Reset state
        else $error("resultReq or done high during reset");

endmodule

bind byteCpu byteCpuAssert assertInst (.*);

// ==== logic/byteCpu.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module byteCpu (
    input  logic                clock,
    input  logic                reset,
    input  logic                loadReq,
    input  logic [`ADDR_W-1:0]  loadAddr,
    input  logic [`DATA_W-1:0]  loadData,
    output logic                loadAck,
    input  logic                run,
    output logic                resultReq,
    output logic [`DATA_W-1:0]  resultOpcode,
    output logic [`DATA_W-1:0]  resultValue,
    output logic [`FLAG_W-1:0]  resultFlags,
    input  logic                resultAck,
    output logic                done
);

    ctrlIf ctrlBus ();                   // Control to datapath strobes

    logic [`ADDR_W-1:0] memAddr;
    logic [`DATA_W-1:0] memData;
    logic [`DATA_W-1:0] ir;
    logic [`DATA_W-1:0] regA;
    logic [`DATA_W-1:0] regB;
    logic [`DATA_W-1:0] regC;
    logic [`DATA_W-1:0] aluResult;
    logic [`FLAG_W-1:0] aluFlagsOut;     // Combinational ALU flags
    logic [`FLAG_W-1:0] flagsReg;        // Latched in execute

    programMemory memoryInst (
        .clock    (clock),
        .reset    (reset),
        .loadReq  (loadReq),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .run      (run),
        .readAddr (memAddr),
        .loadAck  (loadAck),
        .readData (memData)
    );

    controlUnit controlInst (
        .clock        (clock),
        .reset        (reset),
        .run          (run),
        .ir           (ir),
        .c            (regC),
        .b            (regB),
        .flags        (flagsReg),
        .resultAck    (resultAck),
        .ctrl         (ctrlBus.control),
        .resultReq    (resultReq),
        .resultOpcode (resultOpcode),
        .resultValue  (resultValue),
        .resultFlags  (resultFlags),
        .done         (done)
    );

    dataPath dataPathInst (
        .clock      (clock),
        .reset      (reset),
        .ctrl       (ctrlBus.datapath),
        .memData    (memData),
        .aluResult  (aluResult),
        .aluFlagsIn (aluFlagsOut),
        .memAddr    (memAddr),
        .ir         (ir),
        .a          (regA),
        .b          (regB),
        .c          (regC),
        .flags      (flagsReg)
    );

    alu aluInst (
        .a      (regA),
        .b      (regB),
        .aluSel (ctrlBus.aluSel),
        .result (aluResult),
        .flags  (aluFlagsOut)
    );

endmodule

// ==== logic/controlUnit.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module controlUnit import cpuPkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                run,
    input  logic [`DATA_W-1:0]  ir,
    input  logic [`DATA_W-1:0]  c,
    input  logic [`DATA_W-1:0]  b,
    input  aluFlags             flags,
    input  logic                resultAck,
    ctrlIf.control              ctrl,
    output logic                resultReq,
    output logic [`DATA_W-1:0]  resultOpcode,
    output logic [`DATA_W-1:0]  resultValue,
    output aluFlags             resultFlags,
    output logic                done
);

    cpuState    state;
    cpuState    nextState;
    opcodeUnion opView;                  // IR seen as unary or binary select
    logic       isUnary;
    logic       isBinary;
    logic       isJump;
    logic       isHalt;

    assign opView = ir;

    // Instruction class
    always_comb begin
        isUnary  = 1'b0;
        isBinary = 1'b0;
        isJump   = 1'b0;
        isHalt   = 1'b0;
        case (ir)
            `OP_INC, `OP_DEC, `OP_NOT: isUnary = 1'b1;
            `OP_JMP:                   isJump  = 1'b1;
            `OP_ADD, `OP_SUB, `OP_MUL, `OP_AND, `OP_OR,
            `OP_XOR, `OP_NAND, `OP_NOR, `OP_XNOR, `OP_CMP:
                isBinary = 1'b1;
            `OP_HALT: isHalt = 1'b1;
            default:  isHalt = 1'b1;     // Unknown codes stop the CPU
        endcase
    end

    // ALU select from the nibble that carries it
    always_comb begin
        ctrl.aluSel = aluPass;
        if (isUnary) begin
            case (opView.unary.sel)
                4'h1:    ctrl.aluSel = aluAdd;   // Inc with B at one
                4'h2:    ctrl.aluSel = aluSub;   // Dec with B at one
                4'h3:    ctrl.aluSel = aluNot;
                default: ctrl.aluSel = aluPass;
            endcase
        end else if (isBinary) begin
            case (opView.binary.sel)
                4'h1:    ctrl.aluSel = aluAdd;
                4'h2:    ctrl.aluSel = aluSub;
                4'h3:    ctrl.aluSel = aluMul;
                4'h6:    ctrl.aluSel = aluAnd;
                4'h7:    ctrl.aluSel = aluOr;
                4'h8:    ctrl.aluSel = aluXor;
                4'h9:    ctrl.aluSel = aluNand;
                4'hA:    ctrl.aluSel = aluNor;
                4'hB:    ctrl.aluSel = aluXnor;
                4'hC:    ctrl.aluSel = aluCmp;
                default: ctrl.aluSel = aluPass;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= stIdle;
            done  <= 1'b0;
        end else begin
            state <= nextState;
            if (state == stHalt) done <= 1'b1;   // Sticky until reset
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle:      if (run) nextState = stFetchInc;
            stFetchInc:  nextState = stFetchLoad;
            stFetchLoad: nextState = stDecode;
            stDecode: begin
                if (isHalt)      nextState = stHalt;
                else if (isJump) nextState = stBInc;     // Offset is the only operand
                else             nextState = stAInc;
            end
            stAInc:      nextState = stALoad;
            stALoad:     nextState = isBinary ? stBAddr : stExec;
            stBAddr:     nextState = stBInc;
            stBInc:      nextState = stBLoad;
            stBLoad:     nextState = isJump ? stJump : stExec;
            stExec:      nextState = stResultReq;
            stJump:      nextState = stResultReq;
            stResultReq: if (resultAck) nextState = stResultRelease;
            stResultRelease: if (!resultAck) nextState = stFetchInc;
            stHalt:      nextState = stHalt;
            default:     nextState = stIdle;
        endcase
    end

    // Datapath strobes per state
    always_comb begin
        ctrl.irLoad    = 1'b0;
        ctrl.marLoad   = 1'b0;
        ctrl.aLoad     = 1'b0;
        ctrl.bLoad     = 1'b0;
        ctrl.cLoad     = 1'b0;
        ctrl.flagsLoad = 1'b0;
        ctrl.pcInc     = 1'b0;
        ctrl.pcJump    = 1'b0;
        ctrl.bus2Sel   = `BUS2_MEM;
        case (state)
            stIdle:          ctrl.marLoad = run;          // Opcode address
            stFetchInc:      ctrl.pcInc   = 1'b1;
            stFetchLoad:     ctrl.irLoad  = 1'b1;
            stDecode: begin
                ctrl.marLoad = 1'b1;                      // First operand address
                ctrl.bLoad   = 1'b1;                      // Immediate one until B is read
                ctrl.bus2Sel = `BUS2_ONE;
            end
            stAInc:          ctrl.pcInc   = 1'b1;
            stALoad:         ctrl.aLoad   = 1'b1;
            stBAddr:         ctrl.marLoad = 1'b1;
            stBInc:          ctrl.pcInc   = 1'b1;
            stBLoad:         ctrl.bLoad   = 1'b1;
            stExec: begin
                ctrl.cLoad     = 1'b1;
                ctrl.flagsLoad = 1'b1;
                ctrl.bus2Sel   = `BUS2_ALU;
            end
            stJump:          ctrl.pcJump  = 1'b1;         // Relative to next opcode
            stResultRelease: ctrl.marLoad = !resultAck;   // Next opcode address
            default:         ctrl.bus2Sel = `BUS2_MEM;
        endcase
    end

    // Result record held stable by the stalled state
    assign resultReq    = (state == stResultReq);
    assign resultOpcode = ir;
    assign resultValue  = isJump ? b : c;                 // Jump reports its offset
    assign resultFlags  = isJump ? aluFlags'('0) : flags;

endmodule

// ==== logic/dataPath.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module dataPath import cpuPkg::*; (
    input  logic                clock,
    input  logic                reset,
    ctrlIf.datapath             ctrl,
    input  logic [`DATA_W-1:0]  memData,     // Program byte at MAR
    input  logic [`DATA_W-1:0]  aluResult,
    input  aluFlags             aluFlagsIn,
    output logic [`ADDR_W-1:0]  memAddr,
    output logic [`DATA_W-1:0]  ir,
    output logic [`DATA_W-1:0]  a,
    output logic [`DATA_W-1:0]  b,
    output logic [`DATA_W-1:0]  c,
    output aluFlags             flags
);

    logic [`ADDR_W-1:0] pc;              // Wraps at 128
    logic [`ADDR_W-1:0] mar;
    logic [`ADDR_W-1:0] bus1;            // Address bus into MAR
    logic [`DATA_W-1:0] bus2;            // Data bus into IR, A, B, C

    assign bus1 = pc;

    always_comb begin
        case (ctrl.bus2Sel)
            `BUS2_MEM: bus2 = memData;
            `BUS2_ONE: bus2 = `DATA_W'(1);
            `BUS2_ALU: bus2 = aluResult;
            default:   bus2 = memData;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc    <= '0;
            mar   <= '0;
            ir    <= '0;
            a     <= '0;
            b     <= '0;
            c     <= '0;
            flags <= '0;
        end else begin
            if (ctrl.pcJump) begin
                pc <= pc + b[`ADDR_W-1:0];      // Offset taken mod 128
            end else if (ctrl.pcInc) begin
                pc <= pc + 1'b1;
            end
            if (ctrl.marLoad)   mar   <= bus1;
            if (ctrl.irLoad)    ir    <= bus2;
            if (ctrl.aLoad)     a     <= bus2;
            if (ctrl.bLoad)     b     <= bus2;
            if (ctrl.cLoad)     c     <= bus2;
            if (ctrl.flagsLoad) flags <= aluFlagsIn;
        end
    end

    assign memAddr = mar;

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu import cpuPkg::*; (
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    input  aluOp               aluSel,
    output logic [`DATA_W-1:0] result,
    output aluFlags            flags
);

    logic [`DATA_W:0]     sum;          // Extra bit is carry out
    logic [`DATA_W:0]     diff;         // Extra bit is borrow
    logic [2*`DATA_W-1:0] product;

    assign sum     = {1'b0, a} + {1'b0, b};
    assign diff    = {1'b0, a} - {1'b0, b};
    assign product = a * b;

    always_comb begin
        result = '0;
        flags  = '0;
        case (aluSel)
            aluAdd: begin               // Also inc with B at one
                result         = sum[`DATA_W-1:0];
                flags.carry    = sum[`DATA_W];
                flags.overflow = (a[`DATA_W-1] == b[`DATA_W-1]) &&
                                 (result[`DATA_W-1] != a[`DATA_W-1]);
            end
            aluSub: begin               // Also dec with B at one
                result         = diff[`DATA_W-1:0];
                flags.carry    = diff[`DATA_W];  // Set when a below b
                flags.overflow = (a[`DATA_W-1] != b[`DATA_W-1]) &&
                                 (result[`DATA_W-1] != a[`DATA_W-1]);
            end
            aluMul: begin
                result         = product[`DATA_W-1:0];
                flags.overflow = |product[2*`DATA_W-1:`DATA_W];
            end
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluXor:  result = a ^ b;
            aluNand: result = ~(a & b);
            aluNor:  result = ~(a | b);
            aluXnor: result = ~(a ^ b);
            aluNot:  result = ~a;
            aluCmp: begin               // Result stays zero
                flags.zero  = (a == b);
                flags.carry = diff[`DATA_W];
            end
            default: result = a;        // Pass
        endcase

        // Sign, zero and parity track the result except on compare
        if (aluSel != aluCmp) begin
            flags.zero   = (result == '0);
            flags.parity = ^result;
            flags.sign   = (aluSel != aluMul) && result[`DATA_W-1];
        end
    end

endmodule

// ==== logic/programMemory.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

module programMemory (
    input  logic                clock,
    input  logic                reset,
    input  logic                loadReq,    // Host write request
    input  logic [`ADDR_W-1:0]  loadAddr,
    input  logic [`DATA_W-1:0]  loadData,
    input  logic                run,        // Blocks loading while high
    input  logic [`ADDR_W-1:0]  readAddr,   // From MAR
    output logic                loadAck,
    output logic [`DATA_W-1:0]  readData
);

    logic [`DATA_W-1:0] mem [`MEM_DEPTH];   // Program bytes
    logic               loadBusy;           // Byte written and handshake still open
    logic               writeEn;

    // Accept a new byte only from the idle phase
    assign writeEn = loadReq && !loadBusy && !run;

    always_ff @(posedge clock) begin
        if (writeEn) begin
            mem[loadAddr] <= loadData;
        end
    end

    // Two-state load handshake
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            loadBusy <= 1'b0;
            loadAck  <= 1'b0;
        end else if (!loadBusy) begin
            if (writeEn) begin
                loadBusy <= 1'b1;           // Ack follows next cycle
            end
        end else if (loadReq) begin
            loadAck <= 1'b1;                // Hold until request drops
        end else begin
            loadAck  <= 1'b0;
            loadBusy <= 1'b0;               // Ready for the next byte
        end
    end

    assign readData = mem[readAddr];        // Asynchronous read port

endmodule

// ==== logic/ctrlIf.sv ====
`timescale 1ns/1ps
`include "cpu_consts.svh"

interface ctrlIf import cpuPkg::*; ();
    logic irLoad;                       // Register load strobes
    logic marLoad;
    logic aLoad;
    logic bLoad;
    logic cLoad;
    logic flagsLoad;
    logic pcInc;                        // PC plus one
    logic pcJump;                       // PC plus B
    logic [`BUS2_W-1:0] bus2Sel;        // Load source for IR, A, B, C
    aluOp aluSel;

    modport control (
        output irLoad, marLoad, aLoad, bLoad, cLoad, flagsLoad,
        output pcInc, pcJump, bus2Sel, aluSel
    );

    modport datapath (
        input irLoad, marLoad, aLoad, bLoad, cLoad, flagsLoad,
        input pcInc, pcJump, bus2Sel, aluSel
    );
endinterface

// ==== logic/cpuPkg.sv ====
`include "cpu_consts.svh"

package cpuPkg;

    // Opcode byte as a unary select on the low nibble
    typedef struct packed {
        logic [`DATA_W/2-1:0] group;    // Zero for unary ops
        logic [`DATA_W/2-1:0] sel;      // 1 inc, 2 dec, 3 not
    } unaryView;

    // Binary ops select on the high nibble
    typedef struct packed {
        logic [`DATA_W/2-1:0] sel;      // 1 add through C cmp
        logic [`DATA_W/2-1:0] group;    // Zero for binary ops
    } binaryView;

    typedef union packed {
        unaryView  unary;
        binaryView binary;
    } opcodeUnion;

    typedef struct packed {
        logic sign;
        logic carry;                    // Carry out or borrow on sub and cmp
        logic zero;
        logic parity;                   // XOR of result bits
        logic overflow;                 // Signed overflow or mul high byte set
    } aluFlags;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluMul, aluAnd, aluOr, aluXor,
        aluNand, aluNor, aluXnor, aluCmp, aluNot, aluPass
    } aluOp;

    typedef enum logic [3:0] {
        stIdle,                         // Waiting for run
        stFetchInc, stFetchLoad, stDecode,
        stAInc, stALoad,                // Operand A read
        stBAddr, stBInc, stBLoad,       // Operand B or jump offset read
        stExec, stJump,
        stResultReq, stResultRelease,   // Four-phase result handshake
        stHalt
    } cpuState;

endpackage

// ==== logic/cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define DATA_W     8                  // Data byte width
`define ADDR_W     7                  // Program address width
`define MEM_DEPTH  128                // Program store size in bytes
`define FLAG_W     5                  // Sign, carry, zero, parity, overflow

`define BUS2_W     2                  // Bus 2 source select width
`define BUS2_MEM   2'd0               // Program memory read data
`define BUS2_ONE   2'd1               // Constant one for inc and dec
`define BUS2_ALU   2'd2               // ALU result

`define OP_HALT    8'h00
`define OP_INC     8'h01
`define OP_DEC     8'h02
`define OP_NOT     8'h03
`define OP_JMP     8'h04              // Relative jump by inline offset
`define OP_ADD     8'h10
`define OP_SUB     8'h20
`define OP_MUL     8'h30              // Low byte of product
`define OP_AND     8'h60
`define OP_OR      8'h70
`define OP_XOR     8'h80
`define OP_NAND    8'h90
`define OP_NOR     8'hA0
`define OP_XNOR    8'hB0
`define OP_CMP     8'hC0

`endif
